// File: common/nandPinPkg.sv
`default_nettype none

package nandPinPkg;

    localparam int DqWidth   = 32;
    localparam int LaneWidth = 4;

    // flash DQ bus, only the low 16 bits carry command/address bytes
    typedef logic [DqWidth-1:0] dqBus_t;

    // lane group for a single strobe pin (RE, WE, ALE, CLE)
    typedef logic [LaneWidth-1:0] pinLane_t;

    // idle levels while out of reset
    localparam pinLane_t ReadEnableIdle  = 4'b0011;
    localparam pinLane_t WriteEnableIdle = 4'b0001;

    // latch enable levels
    localparam pinLane_t LatchActive   = 4'b0011;
    localparam pinLane_t LatchInactive = 4'b0000;

    localparam pinLane_t PinsReset = 4'b0000;  // every lane group in reset

endpackage

`default_nettype wire

// File: common/cmdSyncPkg.sv
`default_nettype none

package cmdSyncPkg;

    localparam int CaDataWidth = 40;
    localparam int CaByteWidth = 8;
    localparam int CountWidth  = 4;

    typedef logic [CaDataWidth-1:0] caData_t;  // up to five bytes, MSB first on the bus
    typedef logic [CaByteWidth-1:0] caByte_t;

    // index of the last byte, burst length is count + 1
    typedef logic [CountWidth-1:0] byteCount_t;

    localparam byteCount_t MaxByteIndex = 4'd4;

    // cycles of DQ hold-off between latch and first byte
    localparam int HoldOffCycles = 2;

    // one-hot sequencer phases
    typedef enum logic [4:0] {
        resetPhase   = 5'b00001,
        idlePhase    = 5'b00010,
        latchPhase   = 5'b00100,
        holdOffPhase = 5'b01000,
        burstPhase   = 5'b10000
    } seqPhase_t;

endpackage

`default_nettype wire

// File: cmdSync/cmdSyncSequencer.sv
`default_nettype none

module cmdSyncSequencer (
    input  logic                   iSystemClock,
    input  logic                   iReset,
    input  logic                   start,
    input  cmdSyncPkg::byteCount_t lastIndex,
    output cmdSyncPkg::seqPhase_t  phase,
    output logic                   loadRequest,
    output logic                   shiftByte,
    output logic                   ready,
    output logic                   lastStep
);

    import cmdSyncPkg::*;

    localparam int TimerWidth = $clog2(HoldOffCycles + 1);

    seqPhase_t              nextPhase;
    logic [TimerWidth-1:0]  holdOffTimer;
    logic                   holdOffDone;
    byteCount_t             byteCounter;

    assign holdOffDone = (holdOffTimer == TimerWidth'(HoldOffCycles));

    // request is taken at the same edge that leaves idle
    assign loadRequest = (phase == idlePhase) && start;

    // advance to the next byte except after the final one
    assign shiftByte = (phase == burstPhase) && !lastStep;

    always_comb begin
        nextPhase = phase;
        case (phase)
            resetPhase: begin
                nextPhase = idlePhase;
            end
            idlePhase: begin
                if (start) begin
                    nextPhase = latchPhase;
                end
            end
            latchPhase: begin
                nextPhase = holdOffPhase;
            end
            holdOffPhase: begin
                if (holdOffDone) begin
                    nextPhase = burstPhase;
                end
            end
            burstPhase: begin
                if (lastStep) begin
                    nextPhase = idlePhase;
                end
            end
            default: begin
                nextPhase = idlePhase;
            end
        endcase
    end

    // registered from nextPhase so flags line up with the pins
    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            phase    <= resetPhase;
            ready    <= 1'b0;
            lastStep <= 1'b0;
        end else begin
            phase    <= nextPhase;
            ready    <= (nextPhase == idlePhase);
            lastStep <= (nextPhase == burstPhase) && (byteCounter == lastIndex);
        end
    end

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            holdOffTimer <= '0;
        end else if (nextPhase == holdOffPhase) begin
            holdOffTimer <= holdOffTimer + 1'b1;
        end else begin
            holdOffTimer <= '0;
        end
    end

    // counts bytes already put on the bus
    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            byteCounter <= '0;
        end else if (nextPhase == burstPhase) begin
            byteCounter <= byteCounter + 1'b1;
        end else begin
            byteCounter <= '0;
        end
    end

    readyOutsideBurst: assert property (
        @(posedge iSystemClock) disable iff (iReset)
        !(ready && (phase == burstPhase))
    );

    lastStepInBurst: assert property (
        @(posedge iSystemClock) disable iff (iReset)
        lastStep |-> (phase == burstPhase)
    );

endmodule

`default_nettype wire

// File: cmdSync/caByteBuffer.sv
`default_nettype none

module caByteBuffer #(
    parameter int NumberOfWays = 4
) (
    input  logic                    iSystemClock,
    input  logic                    iReset,
    input  logic                    loadRequest,
    input  logic                    shiftByte,
    input  logic [NumberOfWays-1:0] targetWay,
    input  cmdSyncPkg::byteCount_t  numOfData,
    input  logic                    caSelect,
    input  cmdSyncPkg::caData_t     caData,
    output cmdSyncPkg::caByte_t     currentByte,
    output logic [NumberOfWays-1:0] heldWay,
    output logic                    heldSelect,
    output cmdSyncPkg::byteCount_t  lastIndex
);

    import cmdSyncPkg::*;

    localparam int WordWidth = $bits(caData_t);
    localparam int ByteWidth = $bits(caByte_t);

    caData_t wordReg;

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            heldWay    <= '0;
            heldSelect <= 1'b0;
            lastIndex  <= '0;
        end else if (loadRequest) begin
            heldWay    <= targetWay;
            heldSelect <= caSelect;  // high selects command latch
            lastIndex  <= (numOfData > MaxByteIndex) ? MaxByteIndex : numOfData;
        end
    end

    // top byte is on the bus, shift left for the next one
    always_ff @(posedge iSystemClock) begin
        if (loadRequest) begin
            wordReg <= caData;
        end else if (shiftByte) begin
            wordReg <= {wordReg[WordWidth-ByteWidth-1:0], {ByteWidth{1'b0}}};
        end
    end

    assign currentByte = wordReg[WordWidth-1 -: ByteWidth];

    // a new request must never land in the middle of a burst
    loadNotDuringShift: assert property (
        @(posedge iSystemClock) disable iff (iReset)
        !(loadRequest && shiftByte)
    );

endmodule

`default_nettype wire

// File: logic/nandPinDriver.sv
`default_nettype none

module nandPinDriver #(
    parameter int NumberOfWays = 4
) (
    input  cmdSyncPkg::seqPhase_t     phase,
    input  cmdSyncPkg::caByte_t       currentByte,
    input  logic [NumberOfWays-1:0]   heldWay,
    input  logic                      heldSelect,
    output nandPinPkg::dqBus_t        dq,
    output logic [2*NumberOfWays-1:0] chipEnable,
    output nandPinPkg::pinLane_t      readEnable,
    output nandPinPkg::pinLane_t      writeEnable,
    output nandPinPkg::pinLane_t      addressLatchEnable,
    output nandPinPkg::pinLane_t      commandLatchEnable
);

    import cmdSyncPkg::*;
    import nandPinPkg::*;

    always_comb begin
        dq                 = '0;
        chipEnable         = '0;
        readEnable         = ReadEnableIdle;
        writeEnable        = WriteEnableIdle;
        addressLatchEnable = LatchInactive;
        commandLatchEnable = LatchInactive;
        case (phase)
            resetPhase: begin
                readEnable  = PinsReset;
                writeEnable = PinsReset;
            end
            holdOffPhase: begin
                chipEnable = {heldWay, heldWay};  // way shows on both halves
            end
            burstPhase: begin
                chipEnable = {heldWay, heldWay};
                dq         = dqBus_t'({currentByte, currentByte});
                if (heldSelect) begin
                    commandLatchEnable = LatchActive;
                end else begin
                    addressLatchEnable = LatchActive;
                end
            end
            default: begin
                // idle and latch keep the idle levels
            end
        endcase
    end

    always_comb begin
        latchExclusive: assert final (
            !((addressLatchEnable != LatchInactive) && (commandLatchEnable != LatchInactive))
        );
    end

endmodule

`default_nettype wire

// File: logic/cmdSyncTop.sv
`default_nettype none

module cmdSyncTop #(
    parameter int NumberOfWays = 4
) (
    input  logic                      iSystemClock,
    input  logic                      iReset,
    input  logic                      start,
    input  logic [NumberOfWays-1:0]   targetWay,
    input  cmdSyncPkg::byteCount_t    numOfData,
    input  logic                      caSelect,
    input  cmdSyncPkg::caData_t       caData,
    output logic                      ready,
    output logic                      lastStep,
    output nandPinPkg::dqBus_t        dq,
    output logic [2*NumberOfWays-1:0] chipEnable,
    output nandPinPkg::pinLane_t      readEnable,
    output nandPinPkg::pinLane_t      writeEnable,
    output nandPinPkg::pinLane_t      addressLatchEnable,
    output nandPinPkg::pinLane_t      commandLatchEnable
);

    import cmdSyncPkg::*;
    import nandPinPkg::*;

    seqPhase_t               phase;
    logic                    loadRequest;
    logic                    shiftByte;
    caByte_t                 currentByte;
    logic [NumberOfWays-1:0] heldWay;
    logic                    heldSelect;
    byteCount_t              lastIndex;  // already clipped

    cmdSyncSequencer cmdSyncSequencer_inst (
        .iSystemClock (iSystemClock),
        .iReset       (iReset),
        .start        (start),
        .lastIndex    (lastIndex),
        .phase        (phase),
        .loadRequest  (loadRequest),
        .shiftByte    (shiftByte),
        .ready        (ready),
        .lastStep     (lastStep)
    );

    caByteBuffer #(
        .NumberOfWays (NumberOfWays)
    ) caByteBuffer_inst (
        .iSystemClock (iSystemClock),
        .iReset       (iReset),
        .loadRequest  (loadRequest),
        .shiftByte    (shiftByte),
        .targetWay    (targetWay),
        .numOfData    (numOfData),
        .caSelect     (caSelect),
        .caData       (caData),
        .currentByte  (currentByte),
        .heldWay      (heldWay),
        .heldSelect   (heldSelect),
        .lastIndex    (lastIndex)
    );

    nandPinDriver #(
        .NumberOfWays (NumberOfWays)
    ) nandPinDriver_inst (
        .phase              (phase),
        .currentByte        (currentByte),
        .heldWay            (heldWay),
        .heldSelect         (heldSelect),
        .dq                 (dq),
        .chipEnable         (chipEnable),
        .readEnable         (readEnable),
        .writeEnable        (writeEnable),
        .addressLatchEnable (addressLatchEnable),
        .commandLatchEnable (commandLatchEnable)
    );

endmodule

`default_nettype wire

// File: bench/cmdSyncTb.sv
`default_nettype none

module cmdSyncTb;

    timeunit 1ns;
    timeprecision 1ps;

    import cmdSyncPkg::*;
    import nandPinPkg::*;

    localparam int NumberOfWays = 4;
    localparam int NumRows      = 6;

    typedef logic [2*NumberOfWays-1:0] chipEnable_t;

    logic                    iSystemClock;
    logic                    iReset;
    logic                    start;
    logic [NumberOfWays-1:0] targetWay;
    byteCount_t              numOfData;
    logic                    caSelect;
    caData_t                 caData;
    logic                    ready;
    logic                    lastStep;
    dqBus_t                  dq;
    chipEnable_t             chipEnable;
    pinLane_t                readEnable;
    pinLane_t                writeEnable;
    pinLane_t                addressLatchEnable;
    pinLane_t                commandLatchEnable;

    // stimulus table, data of zero is replaced by a random word
    string                   rowName    [NumRows];
    logic [NumberOfWays-1:0] rowWay     [NumRows];
    byteCount_t              rowCount   [NumRows];
    byteCount_t              rowLast    [NumRows];  // expected index of the final byte
    logic                    rowSelect  [NumRows];
    caData_t                 rowData    [NumRows];
    logic                    rowRestart [NumRows];

    logic [31:0] rngState;
    int          errorCount = 0;
    int          testErrors = 0;
    int          testsFailed = 0;
    int          cycleCount = 0;
    int          cycleLimit = 0;
    caByte_t     stream[$];

    cmdSyncTop #(
        .NumberOfWays (NumberOfWays)
    ) cmdSyncTop_inst (
        .iSystemClock       (iSystemClock),
        .iReset             (iReset),
        .start              (start),
        .targetWay          (targetWay),
        .numOfData          (numOfData),
        .caSelect           (caSelect),
        .caData             (caData),
        .ready              (ready),
        .lastStep           (lastStep),
        .dq                 (dq),
        .chipEnable         (chipEnable),
        .readEnable         (readEnable),
        .writeEnable        (writeEnable),
        .addressLatchEnable (addressLatchEnable),
        .commandLatchEnable (commandLatchEnable)
    );

    initial begin
        iSystemClock = 1'b0;
        forever #5 iSystemClock = ~iSystemClock;
    end

    always @(posedge iSystemClock) cycleCount <= cycleCount + 1;

    initial begin
        wait (cycleLimit != 0 && cycleCount >= cycleLimit);
        $display("timeout: run did not finish within %0d cycles", cycleLimit);
        $display("Simulation FAILED");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // byte k of the word, most significant first
    function automatic caByte_t expectedByte(input caData_t word, input int k);
        return word[CaDataWidth-1-8*k -: 8];
    endfunction

    task automatic checkByte(input string test, input string what,
                             input caByte_t expected, input caByte_t actual);
        if (actual !== expected) begin
            $display("mismatch %s %s: expected %h actual %h", test, what, expected, actual);
            testErrors++;
        end
    endtask

    task automatic checkLane(input string test, input string what,
                             input pinLane_t expected, input pinLane_t actual);
        if (actual !== expected) begin
            $display("mismatch %s %s: expected %b actual %b", test, what, expected, actual);
            testErrors++;
        end
    endtask

    task automatic checkChipEnable(input string test, input chipEnable_t expected,
                                   input chipEnable_t actual);
        if (actual !== expected) begin
            $display("mismatch %s chipEnable: expected %b actual %b", test, expected, actual);
            testErrors++;
        end
    endtask

    task automatic checkDq(input string test, input dqBus_t expected, input dqBus_t actual);
        if (actual !== expected) begin
            $display("mismatch %s dq: expected %h actual %h", test, expected, actual);
            testErrors++;
        end
    endtask

    task automatic checkBit(input string test, input string what,
                            input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("mismatch %s %s: expected %b actual %b", test, what, expected, actual);
            testErrors++;
        end
    endtask

    task automatic finishTest(input string test);
        errorCount += testErrors;
        if (testErrors == 0) begin
            $display("test %s: ok", test);
        end else begin
            $display("test %s: %0d errors", test, testErrors);
            testsFailed++;
        end
        testErrors = 0;
    endtask

    task automatic setRow(input int i, input string name, input logic [NumberOfWays-1:0] way,
                          input byteCount_t count, input byteCount_t last, input logic sel,
                          input caData_t data, input logic restart);
        logic [31:0] upper;
        rowName[i]    = name;
        rowWay[i]     = way;
        rowCount[i]   = count;
        rowLast[i]    = last;
        rowSelect[i]  = sel;
        rowRestart[i] = restart;
        rowData[i]    = data;
        if (data == '0) begin
            rngState   = xorshift32(rngState);
            upper      = rngState;
            rngState   = xorshift32(rngState);
            rowData[i] = {upper[31:24], rngState};
        end
    endtask

    task automatic idleLevels(input string test);
        checkDq(test, '0, dq);
        checkChipEnable(test, '0, chipEnable);
        checkLane(test, "readEnable", ReadEnableIdle, readEnable);
        checkLane(test, "writeEnable", WriteEnableIdle, writeEnable);
        checkLane(test, "addressLatchEnable", LatchInactive, addressLatchEnable);
        checkLane(test, "commandLatchEnable", LatchInactive, commandLatchEnable);
    endtask

    task automatic runRow(input int i);
        byteCount_t  n;
        int          k;
        bit          done;
        caByte_t     b;
        n = rowLast[i];
        stream.delete();
        while (ready !== 1'b1) @(negedge iSystemClock);
        @(posedge iSystemClock);
        start     <= 1'b1;
        targetWay <= rowWay[i];
        numOfData <= rowCount[i];
        caSelect  <= rowSelect[i];
        caData    <= rowData[i];
        @(posedge iSystemClock);  // E0
        start <= 1'b0;
        k    = 0;
        done = 1'b0;
        while (!done) begin
            if (k > 0) begin
                @(posedge iSystemClock);
                if (rowRestart[i] && k == 4) begin
                    start     <= 1'b1;  // mid-burst, must be ignored
                    targetWay <= ~rowWay[i];
                    caData    <= ~rowData[i];
                end else begin
                    start <= 1'b0;
                end
            end
            @(negedge iSystemClock);
            if (addressLatchEnable != LatchInactive || commandLatchEnable != LatchInactive)
                stream.push_back(dq[7:0]);
            if (k == 4 + n) begin
                checkBit(rowName[i], "ready", 1'b1, ready);
                checkBit(rowName[i], "lastStep", 1'b0, lastStep);
                idleLevels(rowName[i]);
                done = 1'b1;
            end else begin
                checkBit(rowName[i], "ready", 1'b0, ready);
                checkChipEnable(rowName[i], (k >= 1) ? {rowWay[i], rowWay[i]} : '0, chipEnable);
                if (k >= 3) begin
                    b = expectedByte(rowData[i], k - 3);
                    checkDq(rowName[i], {16'h0000, b, b}, dq);
                    checkLane(rowName[i], "commandLatchEnable",
                              rowSelect[i] ? LatchActive : LatchInactive, commandLatchEnable);
                    checkLane(rowName[i], "addressLatchEnable",
                              rowSelect[i] ? LatchInactive : LatchActive, addressLatchEnable);
                    checkBit(rowName[i], "lastStep", (k - 3) == n, lastStep);
                end else begin
                    checkDq(rowName[i], '0, dq);
                    checkLane(rowName[i], "addressLatchEnable", LatchInactive, addressLatchEnable);
                    checkLane(rowName[i], "commandLatchEnable", LatchInactive, commandLatchEnable);
                    checkBit(rowName[i], "lastStep", 1'b0, lastStep);
                end
            end
            k++;
        end
        if (stream.size() != n + 1) begin
            $display("%s: byte stream has %0d bytes, expected %0d", rowName[i],
                     stream.size(), n + 1);
            testErrors++;
        end else begin
            for (int j = 0; j <= n; j++)
                checkByte(rowName[i], "stream byte", expectedByte(rowData[i], j), stream[j]);
        end
        finishTest(rowName[i]);
    endtask

    initial begin
        int limit;
        iReset    = 1'b1;
        start     = 1'b0;
        targetWay = '0;
        numOfData = '0;
        caSelect  = 1'b0;
        caData    = '0;
        rngState  = 32'd16;
        setRow(0, "cmdSingle",   4'b0001, 4'd0,  4'd0, 1'b1, 40'h70_1122_3344, 1'b0);
        setRow(1, "addrFive",    4'b0100, 4'd4,  4'd4, 1'b0, '0,               1'b0);
        setRow(2, "addrClip",    4'b1000, 4'd9,  4'd4, 1'b0, 40'hA1_B2C3_D4E5, 1'b0);
        setRow(3, "addrRestart", 4'b0010, 4'd3,  4'd3, 1'b0, '0,               1'b1);
        setRow(4, "cmdRestart",  4'b1001, 4'd15, 4'd4, 1'b1, 40'h01_0203_0405, 1'b1);
        setRow(5, "addrShort",   4'b0110, 4'd1,  4'd1, 1'b0, '0,               1'b0);
        limit = 50;
        for (int i = 0; i < NumRows; i++)
            limit += rowCount[i] + 8;
        cycleLimit = limit;

        repeat (7) @(posedge iSystemClock);
        @(negedge iSystemClock);
        checkBit("resetLevels", "ready in reset", 1'b0, ready);
        checkLane("resetLevels", "readEnable in reset", PinsReset, readEnable);
        checkLane("resetLevels", "writeEnable in reset", PinsReset, writeEnable);
        @(posedge iSystemClock);
        iReset <= 1'b0;
        @(posedge iSystemClock);  // first edge out of reset
        @(negedge iSystemClock);
        checkBit("resetLevels", "ready", 1'b1, ready);
        checkBit("resetLevels", "lastStep", 1'b0, lastStep);
        idleLevels("resetLevels");
        finishTest("resetLevels");

        for (int i = 0; i < NumRows; i++)
            runRow(i);

        $display("tests %0d, failed %0d, errors %0d", NumRows + 1, testsFailed, errorCount);
        if (testsFailed == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
common/nandPinPkg.sv
common/cmdSyncPkg.sv
cmdSync/cmdSyncSequencer.sv
cmdSync/caByteBuffer.sv
logic/nandPinDriver.sv
logic/cmdSyncTop.sv
bench/cmdSyncTb.sv
